// ==== hdl/muldiv_pkg.sv ====
// Widths, word types, operation and state encodings, request and divider step structs
package muldiv_pkg;

  ////////////////////
  // Widths

  // Operand and result width
  localparam int XLEN = 32;
  // Step counter covers 1 to DIV_STEPS
  localparam int STEP_CNT_W = 6;
  // Counted divide iterations in EXEC
  localparam int DIV_STEPS = 32;

  ////////////////////
  // Word types

  // One operand or result word
  typedef logic [XLEN-1:0] xlen_t;
  // Operand with one sign extension bit
  typedef logic [XLEN:0] ext_t;
  // Divider adder, two sign bits over the word
  typedef logic [XLEN+1:0] acc_t;

  ////////////////////
  // Encodings

  // Top bit of the opcode splits multiply from divide
  typedef enum logic [2:0] {
    MUL    = 3'd0,
    MULH   = 3'd1,
    MULHSU = 3'd2,
    MULHU  = 3'd3,
    DIV    = 3'd4,
    DIVU   = 3'd5,
    REM    = 3'd6,
    REMU   = 3'd7
  } muldiv_op_e;

  // Controller states
  typedef enum logic [2:0] {
    IDLE,
    EXEC,
    REMD_CHCK,
    QUOT_CORR,
    REMD_CORR
  } muldiv_state_e;

  // Request as held by the requester until consumed
  typedef struct packed {
    muldiv_op_e op;
    xlen_t      rs1;
    xlen_t      rs2;
  } muldiv_req_t;

  // Divider step strobes, one hot while a divide is in flight
  typedef struct packed {
    logic first;
    logic iterate;
    logic check;
    logic quot_corr;
    logic remd_corr;
  } div_step_t;

endpackage

// ==== hdl/muldiv_mul.sv ====
// Combinational multiplier returning the low or high product word
`timescale 1ns/1ps

module muldiv_mul import muldiv_pkg::*; (
  input  muldiv_req_t i_req,
  output xlen_t       o_result
);

  logic              rs1_sign;
  logic              rs2_sign;
  ext_t              op1;
  ext_t              op2;
  xlen_t             mag1;
  xlen_t             mag2;
  logic              prod_neg;
  logic [2*XLEN-1:0] prod_mag;
  logic [2*XLEN-1:0] prod;

  // MULHU treats rs1 as unsigned
  assign rs1_sign = (i_req.op == MULHU) ? 1'b0 : i_req.rs1[XLEN-1];
  // MULHSU and MULHU treat rs2 as unsigned
  assign rs2_sign = ((i_req.op == MULHSU) || (i_req.op == MULHU)) ? 1'b0
                                                                   : i_req.rs2[XLEN-1];

  // 33-bit signed operands
  assign op1 = {rs1_sign, i_req.rs1};
  assign op2 = {rs2_sign, i_req.rs2};

  ////////////////////
  // Sign and magnitude product

  // Most negative word keeps its pattern as an unsigned magnitude
  assign mag1 = op1[XLEN] ? (~op1[XLEN-1:0] + 1'b1) : op1[XLEN-1:0];
  assign mag2 = op2[XLEN] ? (~op2[XLEN-1:0] + 1'b1) : op2[XLEN-1:0];

  assign prod_mag = mag1 * mag2;
  assign prod_neg = op1[XLEN] ^ op2[XLEN];

  // Negate back when the operand signs differ
  assign prod = prod_neg ? (~prod_mag + 1'b1) : prod_mag;

  // Low word for MUL, high word for the three MULH forms
  assign o_result = (i_req.op == MUL) ? prod[XLEN-1:0] : prod[2*XLEN-1:XLEN];

endmodule

// ==== hdl/muldiv_div.sv ====
// Non-restoring divider datapath with correction and special case results
`timescale 1ns/1ps

module muldiv_div import muldiv_pkg::*; (
  input  logic        clk,
  input  logic        i_rst_n,
  input  muldiv_req_t i_req,
  input  div_step_t   i_step,
  output logic        o_need_corr,
  output logic        o_special,
  output xlen_t       o_result
);

  logic  is_div_op;
  logic  signed_op;
  logic  quot_sel;
  logic  rs1_sign;
  logic  rs2_sign;
  acc_t  divisor;
  logic  quot_init;
  logic  prev_quot;
  logic  cur_quot;
  ext_t  step_low;
  ext_t  part_remd_q;
  ext_t  part_quot_q;
  logic  part_remd_sft1_q;
  ext_t  remd_fix;
  ext_t  quot_fix;
  acc_t  alu_op1;
  acc_t  alu_op2;
  logic  alu_sub;
  acc_t  alu_sum;
  logic  remd_is_0;
  logic  remd_is_neg_divs;
  logic  remd_is_divs;
  logic  remd_bad;
  logic  remd_inc_quot_dec;
  ext_t  quot_res;
  ext_t  remd_res;
  logic  div_by_zero;
  logic  div_ovf;
  xlen_t special_res;

  // Operation decode
  assign is_div_op = i_req.op inside {DIV, DIVU, REM, REMU};
  assign signed_op = (i_req.op == DIV) || (i_req.op == REM);
  assign quot_sel  = (i_req.op == DIV) || (i_req.op == DIVU);

  assign rs1_sign = signed_op & i_req.rs1[XLEN-1];
  assign rs2_sign = signed_op & i_req.rs2[XLEN-1];
  assign divisor  = {rs2_sign, rs2_sign, i_req.rs2};

  // First quotient bit is -1 when dividend and divisor signs differ
  assign quot_init = ~(rs1_sign ^ rs2_sign);

  ////////////////////
  // Iteration

  // Previous quotient bit picks subtract or add
  assign prev_quot = i_step.first ? quot_init : part_quot_q[0];
  // Low half of the shift pair, dividend on the first step
  assign step_low  = i_step.first ? {i_req.rs1, quot_init} : part_quot_q;
  assign cur_quot  = ~(alu_sum[XLEN+1] ^ divisor[XLEN+1]);

  // Last iteration stored shifted, undo the shift for check and result
  assign remd_fix = {part_remd_sft1_q, part_remd_q[XLEN:1]};
  // Final quotient bit forced to one
  assign quot_fix = {part_quot_q[XLEN:1], 1'b1};

  // Shared 34-bit add/subtract, operands by step
  always_comb begin
    alu_op1 = {part_remd_sft1_q, part_remd_q};
    alu_op2 = divisor;
    alu_sub = prev_quot;
    if (i_step.first) begin
      alu_op1 = {(XLEN+2){rs1_sign}};
    end else if (i_step.check) begin
      // Remainder plus divisor, zero means remainder is minus the divisor
      alu_op1 = {remd_fix[XLEN], remd_fix};
      alu_sub = 1'b0;
    end else if (i_step.quot_corr) begin
      alu_op1 = {part_quot_q[XLEN], part_quot_q};
      alu_op2 = acc_t'(1);
      alu_sub = remd_inc_quot_dec;
    end else if (i_step.remd_corr) begin
      alu_op1 = {part_remd_q[XLEN], part_remd_q};
      alu_sub = ~remd_inc_quot_dec;
    end
  end

  assign alu_sum = alu_op1 + (alu_op2 ^ {(XLEN+2){alu_sub}}) + acc_t'(alu_sub);

  ////////////////////
  // Remainder check

  assign remd_is_0        = (remd_fix == '0);
  assign remd_is_neg_divs = (alu_sum == '0);
  assign remd_is_divs     = (remd_fix == divisor[XLEN:0]);

  // Sign mismatch with the dividend, or remainder of plus or minus the divisor
  assign remd_bad = ((remd_fix[XLEN] ^ rs1_sign) & ~remd_is_0)
                  | remd_is_neg_divs
                  | remd_is_divs;
  assign o_need_corr = i_step.check & remd_bad;

  // Direction of the correction from the held remainder sign
  assign remd_inc_quot_dec = part_remd_q[XLEN] ^ divisor[XLEN+1];

  // Partial remainder and quotient
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      part_remd_q      <= '0;
      part_quot_q      <= '0;
      part_remd_sft1_q <= 1'b0;
    end else if (i_step.first || i_step.iterate) begin
      part_remd_sft1_q <= alu_sum[XLEN];
      part_remd_q      <= {alu_sum[XLEN-1:0], step_low[XLEN]};
      part_quot_q      <= {step_low[XLEN-1:0], cur_quot};
    end else if (o_need_corr) begin
      // Unshifted form for the correction steps
      part_remd_q <= remd_fix;
      part_quot_q <= quot_fix;
    end else if (i_step.quot_corr) begin
      part_quot_q <= alu_sum[XLEN:0];
    end
  end

  // Remainder correction result goes out straight from the adder
  assign quot_res = i_step.remd_corr ? part_quot_q : quot_fix;
  assign remd_res = i_step.remd_corr ? alu_sum[XLEN:0] : remd_fix;

  ////////////////////
  // Special cases

  assign div_by_zero = (i_req.rs2 == '0);
  // Most negative dividend over -1
  assign div_ovf = signed_op & (&i_req.rs2)
                 & (i_req.rs1 == {1'b1, {(XLEN-1){1'b0}}});
  assign o_special = is_div_op & (div_by_zero | div_ovf);

  always_comb begin
    if (div_by_zero) begin
      special_res = quot_sel ? '1 : i_req.rs1;
    end else begin
      special_res = quot_sel ? {1'b1, {(XLEN-1){1'b0}}} : '0;
    end
  end

  assign o_result = o_special ? special_res
                  : quot_sel  ? quot_res[XLEN-1:0]
                              : remd_res[XLEN-1:0];

endmodule

// ==== hdl/muldiv_ctrl.sv ====
// Controller FSM, step counter, divider strobes, handshake and result select
`timescale 1ns/1ps

module muldiv_ctrl import muldiv_pkg::*; (
  input  logic        clk,
  input  logic        i_rst_n,
  input  logic        i_req_valid,
  input  muldiv_req_t i_req,
  output logic        o_req_ready,
  output logic        o_rsp_valid,
  input  logic        i_rsp_ready,
  output xlen_t       o_rsp_result,
  output div_step_t   o_div_step,
  input  logic        i_need_corr,
  input  logic        i_special,
  input  xlen_t       i_mul_result,
  input  xlen_t       i_div_result
);

  muldiv_state_e           state_q;
  muldiv_state_e           state_d;
  logic [STEP_CNT_W-1:0]   cnt_q;
  logic [STEP_CNT_W-1:0]   cnt_d;
  logic                    is_div;
  logic                    exec_last;
  logic                    wbck_condi;
  logic                    rsp_hsk;

  // Opcode top bit marks a divide
  assign is_div = i_req.op[2];

  // Multiply finishes in its first EXEC cycle, divide after DIV_STEPS
  assign exec_last = is_div ? (cnt_q == STEP_CNT_W'(DIV_STEPS))
                            : (cnt_q == STEP_CNT_W'(1));

  ////////////////////
  // Handshake

  // Result is final in these cases
  assign wbck_condi = i_special
                    | ((state_q == EXEC) & exec_last & ~is_div)
                    | ((state_q == REMD_CHCK) & ~i_need_corr)
                    | (state_q == REMD_CORR);

  assign o_rsp_valid = wbck_condi & i_req_valid;
  // Request consumed together with the response
  assign o_req_ready = o_rsp_valid & i_rsp_ready;
  assign rsp_hsk     = o_req_ready;

  ////////////////////
  // State machine

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    case (state_q)
      IDLE: begin
        // Special cases answer in IDLE
        if (i_req_valid && !i_special) begin
          state_d = EXEC;
          cnt_d   = STEP_CNT_W'(1);
        end
      end
      EXEC: begin
        if (!exec_last) begin
          cnt_d = cnt_q + 1'b1;
        end else if (is_div) begin
          state_d = REMD_CHCK;
        end else if (rsp_hsk) begin
          state_d = IDLE;
        end
      end
      REMD_CHCK: begin
        if (i_need_corr) begin
          state_d = QUOT_CORR;
        end else if (rsp_hsk) begin
          state_d = IDLE;
        end
      end
      QUOT_CORR: state_d = REMD_CORR;
      REMD_CORR: begin
        if (rsp_hsk) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  ////////////////////
  // Divider strobes

  // First step runs in the IDLE cycle that sees the request
  always_comb begin
    o_div_step           = '0;
    o_div_step.first     = is_div & (state_q == IDLE) & i_req_valid & ~i_special;
    o_div_step.iterate   = is_div & (state_q == EXEC);
    o_div_step.check     = is_div & (state_q == REMD_CHCK);
    o_div_step.quot_corr = is_div & (state_q == QUOT_CORR);
    o_div_step.remd_corr = is_div & (state_q == REMD_CORR);
  end

  // Special results come from the divider as well
  assign o_rsp_result = is_div ? i_div_result : i_mul_result;

endmodule

// ==== hdl/muldiv_top.sv ====
// Top level of the multiply/divide unit with controller and both datapaths
`timescale 1ns/1ps

module muldiv_top import muldiv_pkg::*; (
  input  logic        clk,
  input  logic        i_rst_n,
  // Request side
  input  logic        i_req_valid,
  input  muldiv_req_t i_req,
  output logic        o_req_ready,
  // Response side
  output logic        o_rsp_valid,
  input  logic        i_rsp_ready,
  output xlen_t       o_rsp_result
);

  // Controller to divider
  div_step_t div_step;
  // Divider status back to the controller
  logic      div_need_corr;
  logic      div_special;
  // Datapath results
  xlen_t     mul_result;
  xlen_t     div_result;

  muldiv_ctrl u_ctrl (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_req_valid  (i_req_valid),
    .i_req        (i_req),
    .o_req_ready  (o_req_ready),
    .o_rsp_valid  (o_rsp_valid),
    .i_rsp_ready  (i_rsp_ready),
    .o_rsp_result (o_rsp_result),
    .o_div_step   (div_step),
    .i_need_corr  (div_need_corr),
    .i_special    (div_special),
    .i_mul_result (mul_result),
    .i_div_result (div_result)
  );

  // Multiply is purely combinational on the held request
  muldiv_mul u_mul (
    .i_req    (i_req),
    .o_result (mul_result)
  );

  muldiv_div u_div (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_req       (i_req),
    .i_step      (div_step),
    .o_need_corr (div_need_corr),
    .o_special   (div_special),
    .o_result    (div_result)
  );

endmodule

// ==== tb/muldiv_properties.sv ====
// Handshake and response stability assertions for the multiply/divide top level
`timescale 1ns/1ps

module muldiv_properties import muldiv_pkg::*; (
  input logic        clk,
  input logic        i_rst_n,
  input logic        i_req_valid,
  input muldiv_req_t i_req,
  input logic        o_req_ready,
  input logic        o_rsp_valid,
  input logic        i_rsp_ready,
  input xlen_t       o_rsp_result
);

  // Assertion failures so far
  int assert_fail_cnt = 0;

  ////////////////////
  // Handshake

  // No response without a live request
  a_valid_needs_req: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_rsp_valid |-> i_req_valid)
    else begin
      $error("o_rsp_valid high without i_req_valid");
      assert_fail_cnt++;
    end

  // Requester keeps the request until it is consumed
  a_req_held: assert property (@(posedge clk) disable iff (!i_rst_n)
    (i_req_valid && !o_req_ready) |=> (i_req_valid && $stable(i_req)))
    else begin
      $error("request changed before it was consumed");
      assert_fail_cnt++;
    end

  ////////////////////
  // Response

  // Result frozen while the response waits
  a_result_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
    (o_rsp_valid && !i_rsp_ready) |=> $stable(o_rsp_result))
    else begin
      $error("o_rsp_result changed under back-pressure");
      assert_fail_cnt++;
    end

  // Reset keeps the request side closed
  a_no_ready_in_reset: assert property (@(posedge clk)
    !i_rst_n |-> !o_req_ready)
    else begin
      $error("o_req_ready high during reset");
      assert_fail_cnt++;
    end

endmodule

bind muldiv_top muldiv_properties u_props (.*);

// ==== tb/muldiv_tb.sv ====
// Testbench for the multiply/divide unit with file stimulus, ready throttling and watchdog
`timescale 1ns/1ps

module muldiv_tb import muldiv_pkg::*; ();

  logic        clk;
  logic        i_rst_n;
  logic        i_req_valid;
  muldiv_req_t i_req;
  logic        o_req_ready;
  logic        o_rsp_valid;
  logic        i_rsp_ready;
  xlen_t       o_rsp_result;

  // Tests as read from the stimulus file
  string       names[$];
  logic [2:0]  ops[$];
  xlen_t       rs1s[$];
  xlen_t       rs2s[$];
  xlen_t       exps[$];

  int          n_tests;
  int          test_err;
  int          pass_count;
  int          fail_count;
  int          hsk_count;
  int unsigned seed_val;
  bit          load_ok;

  muldiv_top UUT (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_req_valid  (i_req_valid),
    .i_req        (i_req),
    .o_req_ready  (o_req_ready),
    .o_rsp_valid  (o_rsp_valid),
    .i_rsp_ready  (i_rsp_ready),
    .o_rsp_result (o_rsp_result)
  );

  // 8 ns clock
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Random back-pressure with ready high three cycles in four on average
  initial begin
    seed_val    = $urandom(32'ha7c9);
    i_rsp_ready = 1'b0;
    wait (i_rst_n);
    forever begin
      @(posedge clk);
      #1 i_rsp_ready = ($urandom_range(3) != 0);
    end
  end

  // Ready at a falling edge means the request is consumed at the next rising edge
  always @(negedge clk) begin
    if (i_rst_n && o_req_ready) begin
      hsk_count++;
    end
  end

  // Budget of 40 cycles per test plus 50 for reset and gaps
  initial begin
    wait (n_tests > 0);
    repeat (40 * n_tests + 50) @(posedge clk);
    $display("Watchdog: the run timed out, the DUT stopped answering");
    $display("Something failed");
    $finish;
  end

  ////////////////////
  // Helpers

  task automatic check_value(input string test_name, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERROR %s %s: expected 0x%08h, actual 0x%08h", test_name, what, expected, actual);
      test_err++;
    end
  endtask

  // One line per finished test
  task automatic report_test(input string test_name, input int lat);
    if (test_err == 0) begin
      pass_count++;
      $display("%-12s pass (latency %0d)", test_name, lat);
    end else begin
      fail_count++;
      $display("%-12s fail (latency %0d)", test_name, lat);
    end
  endtask

  // Divide by zero for any divide and overflow only for the signed ones
  function automatic bit is_special(input logic [2:0] op, input xlen_t a, input xlen_t b);
    bit signed_div;
    signed_div = (op == 3'd4) || (op == 3'd6);
    is_special = op[2] && ((b == '0) || (signed_div && (a == 32'h8000_0000) && (b == '1)));
  endfunction

  task automatic load_stimulus(output bit ok);
    int         fd;
    int         n;
    string      line;
    string      name;
    logic [31:0] op_val;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] e;
    ok = 1'b0;
    fd = $fopen("tb/muldiv_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file tb/muldiv_stimulus.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        n = $sscanf(line, "%s %h %h %h %h", name, op_val, a, b, e);
        // Comment and blank lines do not give five fields
        if ((n == 5) && (name != "#")) begin
          names.push_back(name);
          ops.push_back(op_val[2:0]);
          rs1s.push_back(a);
          rs2s.push_back(b);
          exps.push_back(e);
        end
      end
      $fclose(fd);
      ok = (names.size() > 0);
      if (!ok) begin
        $display("The stimulus file holds no tests");
      end
    end
  endtask

  ////////////////////
  // One request

  // Entered 1 ns after a rising edge and left 1 ns after the consuming edge
  task automatic run_test(input int idx);
    muldiv_req_t req;
    int          lat;
    xlen_t       got;
    req.op      = muldiv_op_e'(ops[idx]);
    req.rs1     = rs1s[idx];
    req.rs2     = rs2s[idx];
    i_req       = req;
    i_req_valid = 1'b1;
    test_err    = 0;
    lat         = 0;
    // Count rising edges until the response shows up
    @(negedge clk);
    while (!o_rsp_valid) begin
      @(posedge clk);
      lat++;
      @(negedge clk);
    end
    if (is_special(ops[idx], rs1s[idx], rs2s[idx])) begin
      check_value(names[idx], "latency", 0, lat);
    end else if (!ops[idx][2]) begin
      check_value(names[idx], "latency", 1, lat);
    end else if ((lat != 33) && (lat != 35)) begin
      $display("%s: the divide answered after %0d cycles instead of 33 or 35", names[idx], lat);
      test_err++;
    end
    // Hold until the response is accepted
    while (!o_req_ready) begin
      @(negedge clk);
    end
    got = o_rsp_result;
    @(posedge clk);
    #1;
    check_value(names[idx], "result", exps[idx], got);
    report_test(names[idx], lat);
  endtask

  ////////////////////
  // Main sequence

  initial begin
    i_rst_n     = 1'b0;
    i_req_valid = 1'b0;
    i_req       = '0;
    n_tests     = 0;
    pass_count  = 0;
    fail_count  = 0;
    hsk_count   = 0;
    load_stimulus(load_ok);
    if (!load_ok) begin
      fail_count++;
    end else begin
      n_tests = names.size();
      repeat (3) @(posedge clk);
      #1 i_rst_n = 1'b1;
      // Idle outputs stay low with no request
      test_err = 0;
      repeat (3) begin
        @(negedge clk);
        check_value("reset", "o_rsp_valid", 0, o_rsp_valid);
        check_value("reset", "o_req_ready", 0, o_req_ready);
      end
      report_test("reset", 0);
      @(posedge clk);
      #1;
      for (int i = 0; i < n_tests; i++) begin
        run_test(i);
        // Mix of back-to-back requests and short idle gaps
        if ((i % 3) != 0) begin
          i_req_valid = 1'b0;
          repeat (i % 3) @(posedge clk);
          #1;
        end
      end
      i_req_valid = 1'b0;
      repeat (2) @(posedge clk);
      test_err = 0;
      check_value("handshakes", "count", n_tests, hsk_count);
      report_test("handshakes", 0);
      // Bound handshake and stability assertions
      test_err = 0;
      check_value("assertions", "failures", 0, UUT.u_props.assert_fail_cnt);
      report_test("assertions", 0);
    end
    $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== tb/muldiv_stimulus.txt ====
# Columns: test name, operation code (0 MUL .. 7 REMU), rs1, rs2, expected result, all hex
# Lines starting with # are skipped
mul_ovf     0 80000000 ffffffff 80000000
mulh_neg    1 80000000 ffffffff 00000000
mulh_min    1 80000000 80000000 40000000
mulhsu_neg  2 ffffffff ffffffff ffffffff
mulhu_max   3 ffffffff ffffffff fffffffe
div_pos     4 00000064 00000007 0000000e
divu_big    5 ffffffff 00000010 0fffffff
rem_pos     6 00000064 00000007 00000002
remu_big    7 ffffffff 00000010 0000000f
div_neg     4 fffffff9 00000002 fffffffd
rem_neg     6 fffffff9 00000002 ffffffff
rem_negdiv  6 00000007 fffffffe 00000001
div_exact   4 fffffff4 00000004 fffffffd
divu_exact  5 00000015 00000007 00000003
remu_exact  7 00000015 00000007 00000000
div_zero    4 12345678 00000000 ffffffff
remu_zero   7 12345678 00000000 12345678
div_ovf     4 80000000 ffffffff 80000000
rem_ovf     6 80000000 ffffffff 00000000

// ==== sources.f ====
hdl/muldiv_pkg.sv
hdl/muldiv_mul.sv
hdl/muldiv_div.sv
hdl/muldiv_ctrl.sv
hdl/muldiv_top.sv
tb/muldiv_properties.sv
tb/muldiv_tb.sv
